//--- hw/wq_mgr_pkg.sv
package wq_mgr_pkg;

  localparam int unsigned MTU_BYTES  = 4096;
  localparam int unsigned JOB_DEPTH  = 8;
  localparam int unsigned JOB_PTR_W  = $clog2(JOB_DEPTH);
  localparam int unsigned AXI_DATA_W = 512;
  localparam int unsigned WQE_BYTES  = 64;
  localparam int unsigned CQE_BYTES  = 4;

  // work-queue element opcodes
  typedef enum logic [7:0] {
    WQE_WRITE = 8'h00,
    WQE_SEND  = 8'h02,
    WQE_READ  = 8'h04
  } wqe_op_e;

  // request opcodes toward the RC engine
  typedef enum logic [4:0] {
    SEND_FIRST   = 5'd0,
    SEND_MIDDLE  = 5'd1,
    SEND_LAST    = 5'd2,
    SEND_ONLY    = 5'd4,
    WRITE_FIRST  = 5'd6,
    WRITE_MIDDLE = 5'd7,
    WRITE_LAST   = 5'd8,
    WRITE_ONLY   = 5'd10,
    READ_REQUEST = 5'd12
  } rc_op_e;

  typedef struct packed {
    logic [7:0]  qp_idx;
    logic [31:0] prod_idx;
    logic [31:0] head_idx;
    logic [63:0] sq_base;
    logic [63:0] cq_base;
  } sq_job_t;

  typedef struct packed {
    logic [15:0] wr_id;
    logic [63:0] local_addr;
    logic [31:0] length;
    wqe_op_e     opcode;
    logic [63:0] remote_addr;
  } wqe_t;

  typedef struct packed {
    rc_op_e      opcode;
    logic [15:0] qpn;
    logic        last;
    logic [63:0] remote_addr;
    logic [63:0] local_addr;
    logic [31:0] length;
  } sq_req_t;

  // wr_id sits in the low bits
  typedef struct packed {
    logic [7:0]  status;
    logic [7:0]  opcode;
    logic [15:0] wr_id;
  } cqe_t;

endpackage

//--- hw/wqe_fetch_if.sv
interface wqe_fetch_if;

  logic               req;
  logic [63:0]        base;
  logic [31:0]        index;
  logic               done;
  wq_mgr_pkg::wqe_t   wqe;

  modport seg (
    output req, base, index,
    input  done, wqe
  );

  modport fetch (
    input  req, base, index,
    output done, wqe
  );

endinterface

//--- hw/cpl_write_if.sv
interface cpl_write_if;

  logic               req;
  logic [63:0]        cq_base;
  logic [7:0]         qp_idx;
  logic [31:0]        index;
  wq_mgr_pkg::cqe_t   cqe;
  logic               done;

  modport seg (
    output req, cq_base, qp_idx, index, cqe,
    input  done
  );

  modport wb (
    input  req, cq_base, qp_idx, index, cqe,
    output done
  );

endinterface

//--- hw/sq_doorbell_queue.sv
module sq_doorbell_queue (
  input  logic                axis_aclk_i,
  input  logic                axis_rstn_i,
  input  logic                sq_updated_i,
  input  logic [7:0]          qp_idx_i,
  input  logic [31:0]         sq_prod_idx_i,
  input  logic [31:0]         cq_head_idx_i,
  input  logic [63:0]         sq_base_i,
  input  logic [63:0]         cq_base_i,
  output wq_mgr_pkg::sq_job_t job_o,
  output logic                job_valid_o,
  input  logic                job_pop_i
);
  import wq_mgr_pkg::*;

  sq_job_t              mem [JOB_DEPTH];
  sq_job_t              db_job_q;
  logic                 db_valid_q;
  logic [JOB_PTR_W-1:0] wr_ptr_q;
  logic [JOB_PTR_W-1:0] rd_ptr_q;
  logic [JOB_PTR_W:0]   count_q;
  logic                 full;
  logic                 push;
  logic                 pop;

  // a registered doorbell still owns a slot
  assign full = (count_q + db_valid_q) >= JOB_DEPTH;
  assign push = db_valid_q;
  assign pop  = job_pop_i && (count_q != '0);

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      db_valid_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      db_valid_q <= sq_updated_i && !full;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (sq_updated_i) begin
      db_job_q <= '{qp_idx: qp_idx_i, prod_idx: sq_prod_idx_i, head_idx: cq_head_idx_i,
                    sq_base: sq_base_i, cq_base: cq_base_i};
    end
    if (push) mem[wr_ptr_q] <= db_job_q;
  end

  // first-word fall-through
  assign job_o       = mem[rd_ptr_q];
  assign job_valid_o = count_q != '0;

endmodule

//--- hw/wqe_fetch.sv
module wqe_fetch (
  input  logic                              axis_aclk_i,
  input  logic                              axis_rstn_i,
  wqe_fetch_if.fetch                        fetch,
  output logic [63:0]                       araddr_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,
  input  logic [wq_mgr_pkg::AXI_DATA_W-1:0] rdata_i,
  input  logic                              rvalid_i,
  input  logic                              rlast_i,
  output logic                              rready_o
);
  import wq_mgr_pkg::*;

  typedef enum logic [1:0] {FT_IDLE, FT_ADDR, FT_DATA} fetch_state_e;

  fetch_state_e state_q;
  logic         done_q;
  logic [63:0]  araddr_q;
  wqe_t         wqe_q;
  wqe_t         rd_wqe;

  // element layout in the 64-byte line
  always_comb begin
    rd_wqe.wr_id       = rdata_i[15:0];
    rd_wqe.local_addr  = rdata_i[95:32];
    rd_wqe.length      = rdata_i[127:96];
    rd_wqe.opcode      = wqe_op_e'(rdata_i[135:128]);
    rd_wqe.remote_addr = rdata_i[223:160];
  end

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= FT_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        FT_IDLE: if (fetch.req) state_q <= FT_ADDR;
        FT_ADDR: if (arready_i) state_q <= FT_DATA;
        FT_DATA: begin
          if (rvalid_i && rlast_i) begin
            done_q  <= 1'b1;
            state_q <= FT_IDLE;
          end
        end
        default: state_q <= FT_IDLE;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (state_q == FT_IDLE && fetch.req) araddr_q <= fetch.base + 64'(fetch.index) * WQE_BYTES;
    if (state_q == FT_DATA && rvalid_i && rlast_i) wqe_q <= rd_wqe;
  end

  assign araddr_o   = araddr_q;
  assign arvalid_o  = state_q == FT_ADDR;
  assign rready_o   = state_q == FT_DATA;
  assign fetch.done = done_q;
  assign fetch.wqe  = wqe_q;

endmodule

//--- hw/sq_segmenter.sv
module sq_segmenter (
  input  logic                axis_aclk_i,
  input  logic                axis_rstn_i,
  input  wq_mgr_pkg::sq_job_t job_i,
  input  logic                job_valid_i,
  output logic                job_pop_o,
  wqe_fetch_if.seg            fetch,
  cpl_write_if.seg            cpl,
  output wq_mgr_pkg::sq_req_t sq_req_o,
  output logic                sq_req_valid_o,
  input  logic                sq_req_ready_i,
  input  logic                ack_valid_i,
  output logic                ack_ready_o
);
  import wq_mgr_pkg::*;

  typedef enum logic [2:0] {IDLE, CHECK, FETCH, ISSUE, WAIT_ACK, COMPLETE} seg_state_e;

  seg_state_e  state_q, state_d;
  logic        fetch_req_q, fetch_req_d;
  logic        cpl_req_q, cpl_req_d;
  sq_job_t     job_q;
  logic [31:0] idx_q;
  wqe_op_e     op_q;
  logic [31:0] rem_q;
  logic [63:0] lcl_q;
  logic [63:0] rmt_q;
  logic        first_q;
  logic [7:0]  status_q;
  logic        wqe_known;
  logic        req_last;
  logic        req_xfer;

  assign wqe_known = fetch.wqe.opcode inside {WQE_WRITE, WQE_SEND, WQE_READ};
  assign req_xfer  = (state_q == ISSUE) && sq_req_ready_i;

  ////////////////////
  // request builder
  ////////////////////
  always_comb begin
    req_last             = (op_q == WQE_READ) || (rem_q <= MTU_BYTES);
    sq_req_o.qpn         = {8'b0, job_q.qp_idx};
    sq_req_o.last        = req_last;
    sq_req_o.remote_addr = (op_q == WQE_SEND) ? 64'd0 : rmt_q;
    sq_req_o.local_addr  = lcl_q;
    sq_req_o.length      = req_last ? rem_q : MTU_BYTES;
    case (op_q)
      WQE_READ: sq_req_o.opcode = READ_REQUEST;
      WQE_SEND: begin
        if (first_q) sq_req_o.opcode = req_last ? SEND_ONLY : SEND_FIRST;
        else sq_req_o.opcode = req_last ? SEND_LAST : SEND_MIDDLE;
      end
      default: begin
        if (first_q) sq_req_o.opcode = req_last ? WRITE_ONLY : WRITE_FIRST;
        else sq_req_o.opcode = req_last ? WRITE_LAST : WRITE_MIDDLE;
      end
    endcase
  end

  ////////////////////
  // job FSM
  ////////////////////
  always_comb begin
    state_d     = state_q;
    job_pop_o   = 1'b0;
    ack_ready_o = 1'b0;
    fetch_req_d = 1'b0;
    cpl_req_d   = 1'b0;
    case (state_q)
      IDLE: begin
        if (job_valid_i) begin
          job_pop_o = 1'b1;
          state_d   = CHECK;
        end
      end
      CHECK: begin
        // nothing outstanding, drop the job
        if (job_q.prod_idx > job_q.head_idx) begin
          fetch_req_d = 1'b1;
          state_d     = FETCH;
        end else begin
          state_d = IDLE;
        end
      end
      FETCH: begin
        if (fetch.done) begin
          if (wqe_known) begin
            state_d = ISSUE;
          end else begin
            cpl_req_d = 1'b1;
            state_d   = COMPLETE;
          end
        end
      end
      ISSUE: if (req_xfer && req_last) state_d = WAIT_ACK;
      WAIT_ACK: begin
        if (ack_valid_i) begin
          ack_ready_o = 1'b1;
          cpl_req_d   = 1'b1;
          state_d     = COMPLETE;
        end
      end
      COMPLETE: begin
        if (cpl.done) begin
          if (idx_q < job_q.prod_idx) begin
            fetch_req_d = 1'b1;
            state_d     = FETCH;
          end else begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q     <= IDLE;
      fetch_req_q <= 1'b0;
      cpl_req_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      fetch_req_q <= fetch_req_d;
      cpl_req_q   <= cpl_req_d;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (job_pop_o) job_q <= job_i;
    if (state_q == CHECK) idx_q <= job_q.head_idx;
    // completion carries the new head
    if (cpl_req_d) idx_q <= idx_q + 32'd1;
    if (state_q == FETCH && fetch.done) begin
      op_q     <= fetch.wqe.opcode;
      rem_q    <= fetch.wqe.length;
      lcl_q    <= fetch.wqe.local_addr;
      rmt_q    <= fetch.wqe.remote_addr;
      first_q  <= 1'b1;
      status_q <= wqe_known ? 8'd0 : 8'd1;
    end
    if (req_xfer) begin
      rem_q   <= rem_q - MTU_BYTES;
      lcl_q   <= lcl_q + MTU_BYTES;
      rmt_q   <= rmt_q + MTU_BYTES;
      first_q <= 1'b0;
    end
  end

  assign sq_req_valid_o = state_q == ISSUE;

  assign fetch.req   = fetch_req_q;
  assign fetch.base  = job_q.sq_base;
  assign fetch.index = idx_q;

  assign cpl.req        = cpl_req_q;
  assign cpl.cq_base    = job_q.cq_base;
  assign cpl.qp_idx     = job_q.qp_idx;
  assign cpl.index      = idx_q;
  assign cpl.cqe.wr_id  = fetch.wqe.wr_id;
  assign cpl.cqe.opcode = fetch.wqe.opcode;
  assign cpl.cqe.status = status_q;

endmodule

//--- hw/cq_writeback.sv
module cq_writeback (
  input  logic             axis_aclk_i,
  input  logic             axis_rstn_i,
  cpl_write_if.wb          cpl,
  output logic [63:0]      awaddr_o,
  output logic             awvalid_o,
  input  logic             awready_i,
  output wq_mgr_pkg::cqe_t wdata_o,
  output logic             wvalid_o,
  output logic             wlast_o,
  input  logic             wready_i,
  input  logic             bvalid_i,
  output logic             bready_o,
  output logic [39:0]      cq_head_o,
  output logic             cq_head_valid_o
);
  import wq_mgr_pkg::*;

  typedef enum logic [1:0] {WB_IDLE, WB_AW, WB_W, WB_B} wb_state_e;

  wb_state_e   state_q;
  logic [63:0] awaddr_q;
  cqe_t        cqe_q;
  logic [7:0]  qp_q;
  logic [31:0] head_q;
  logic        b_done;

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= WB_IDLE;
    end else begin
      case (state_q)
        WB_IDLE: if (cpl.req) state_q <= WB_AW;
        WB_AW:   if (awready_i) state_q <= WB_W;
        WB_W:    if (wready_i) state_q <= WB_B;
        WB_B:    if (bvalid_i) state_q <= WB_IDLE;
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  // slot of the element that just finished
  always_ff @(posedge axis_aclk_i) begin
    if (state_q == WB_IDLE && cpl.req) begin
      awaddr_q <= cpl.cq_base + 64'(cpl.index - 32'd1) * CQE_BYTES;
      cqe_q    <= cpl.cqe;
      qp_q     <= cpl.qp_idx;
      head_q   <= cpl.index;
    end
  end

  assign b_done = (state_q == WB_B) && bvalid_i;

  assign awaddr_o  = awaddr_q;
  assign awvalid_o = state_q == WB_AW;
  assign wdata_o   = cqe_q;
  assign wvalid_o  = state_q == WB_W;
  assign wlast_o   = state_q == WB_W;
  assign bready_o  = 1'b1;

  assign cpl.done        = b_done;
  assign cq_head_o       = {qp_q, head_q};
  assign cq_head_valid_o = b_done;

endmodule

//--- hw/wq_mgr_top.sv
module wq_mgr_top (
  input  logic                              axis_aclk_i,
  input  logic                              axis_rstn_i,
  input  logic                              sq_updated_i,
  input  logic [7:0]                        qp_idx_i,
  input  logic [31:0]                       sq_prod_idx_i,
  input  logic [31:0]                       cq_head_idx_i,
  input  logic [63:0]                       sq_base_i,
  input  logic [63:0]                       cq_base_i,
  output logic [63:0]                       araddr_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,
  input  logic [wq_mgr_pkg::AXI_DATA_W-1:0] rdata_i,
  input  logic                              rvalid_i,
  input  logic                              rlast_i,
  output logic                              rready_o,
  output logic [63:0]                       awaddr_o,
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output wq_mgr_pkg::cqe_t                  wdata_o,
  output logic                              wvalid_o,
  output logic                              wlast_o,
  input  logic                              wready_i,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  output wq_mgr_pkg::sq_req_t               sq_req_o,
  output logic                              sq_req_valid_o,
  input  logic                              sq_req_ready_i,
  input  logic                              ack_valid_i,
  output logic                              ack_ready_o,
  output logic [39:0]                       cq_head_o,
  output logic                              cq_head_valid_o
);
  import wq_mgr_pkg::*;

  sq_job_t job;
  logic    job_valid;
  logic    job_pop;

  wqe_fetch_if fetch_bus ();
  cpl_write_if cpl_bus ();

  sq_doorbell_queue i_sq_doorbell_queue (
    .axis_aclk_i, .axis_rstn_i, .sq_updated_i, .qp_idx_i, .sq_prod_idx_i,
    .cq_head_idx_i, .sq_base_i, .cq_base_i,
    .job_o(job), .job_valid_o(job_valid), .job_pop_i(job_pop)
  );

  wqe_fetch i_wqe_fetch (
    .axis_aclk_i, .axis_rstn_i, .fetch(fetch_bus.fetch),
    .araddr_o, .arvalid_o, .arready_i, .rdata_i, .rvalid_i, .rlast_i, .rready_o
  );

  sq_segmenter i_sq_segmenter (
    .axis_aclk_i, .axis_rstn_i, .job_i(job), .job_valid_i(job_valid), .job_pop_o(job_pop),
    .fetch(fetch_bus.seg), .cpl(cpl_bus.seg),
    .sq_req_o, .sq_req_valid_o, .sq_req_ready_i, .ack_valid_i, .ack_ready_o
  );

  cq_writeback i_cq_writeback (
    .axis_aclk_i, .axis_rstn_i, .cpl(cpl_bus.wb),
    .awaddr_o, .awvalid_o, .awready_i, .wdata_o, .wvalid_o, .wlast_o, .wready_i,
    .bvalid_i, .bready_o, .cq_head_o, .cq_head_valid_o
  );

endmodule

//--- verification/tb_wq_mgr_assert.sv
module tb_wq_mgr_assert (
  input logic                axis_aclk_i,
  input logic                axis_rstn_i,
  input wq_mgr_pkg::sq_req_t sq_req_o,
  input logic                sq_req_valid_o,
  input logic                sq_req_ready_i,
  input logic [63:0]         araddr_o,
  input logic                arvalid_o,
  input logic                arready_i,
  input logic [63:0]         awaddr_o,
  input logic                awvalid_o,
  input logic                awready_i,
  input logic                ack_valid_i,
  input logic                ack_ready_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;
  logic        ack_due;

  // an ack is owed once the last request of an element has transferred
  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      ack_due <= 1'b0;
    end else if (sq_req_valid_o && sq_req_ready_i && sq_req_o.last) begin
      ack_due <= 1'b1;
    end else if (ack_valid_i && ack_ready_o) begin
      ack_due <= 1'b0;
    end
  end

  // payload must hold while the slave stalls
  req_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    sq_req_valid_o && !sq_req_ready_i |=> sq_req_valid_o && $stable(sq_req_o))
    else begin
      fail_cnt++;
      $error("sq_req_o changed while the request was stalled");
    end

  ar_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else begin
      fail_cnt++;
      $error("araddr_o changed while the read address was stalled");
    end

  aw_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else begin
      fail_cnt++;
      $error("awaddr_o changed while the write address was stalled");
    end

  ack_taken: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    ack_ready_o |-> ack_valid_i && ack_due)
    else begin
      fail_cnt++;
      $error("ack_ready_o high without an owed ack on ack_valid_i");
    end

endmodule

bind wq_mgr_top tb_wq_mgr_assert i_tb_wq_mgr_assert (
  .axis_aclk_i(axis_aclk_i), .axis_rstn_i(axis_rstn_i),
  .sq_req_o(sq_req_o), .sq_req_valid_o(sq_req_valid_o), .sq_req_ready_i(sq_req_ready_i),
  .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
  .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
  .ack_valid_i(ack_valid_i), .ack_ready_o(ack_ready_o)
);

//--- verification/tb_wq_mgr.sv
module tb_wq_mgr;
  timeunit 1ns;
  timeprecision 100ps;
  import wq_mgr_pkg::*;

  // about 13x the 1500 cycles the cases take together
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam logic [63:0] SQ_BASE        = 64'h0000_1000_0000_0000;
  localparam logic [63:0] CQ_BASE        = 64'h0000_2000_0000_0000;

  logic                  axis_aclk_i     = 1'b0;
  logic                  axis_rstn_i     = 1'b0;
  logic                  sq_updated_i    = 1'b0;
  logic [7:0]            qp_idx_i        = '0;
  logic [31:0]           sq_prod_idx_i   = '0;
  logic [31:0]           cq_head_idx_i   = '0;
  logic [63:0]           sq_base_i       = '0;
  logic [63:0]           cq_base_i       = '0;
  logic [63:0]           araddr_o;
  logic                  arvalid_o;
  logic                  arready_i       = 1'b0;
  logic [AXI_DATA_W-1:0] rdata_i         = '0;
  logic                  rvalid_i        = 1'b0;
  logic                  rlast_i         = 1'b0;
  logic                  rready_o;
  logic [63:0]           awaddr_o;
  logic                  awvalid_o;
  logic                  awready_i       = 1'b0;
  cqe_t                  wdata_o;
  logic                  wvalid_o;
  logic                  wlast_o;
  logic                  wready_i        = 1'b0;
  logic                  bvalid_i        = 1'b0;
  logic                  bready_o;
  sq_req_t               sq_req_o;
  logic                  sq_req_valid_o;
  logic                  sq_req_ready_i  = 1'b0;
  logic                  ack_valid_i     = 1'b0;
  logic                  ack_ready_o;
  logic [39:0]           cq_head_o;
  logic                  cq_head_valid_o;

  logic [AXI_DATA_W-1:0] wqe_mem [logic [63:0]];
  sq_req_t               req_log [$];
  logic [63:0]           ar_log [$];
  logic [63:0]           aw_log [$];
  cqe_t                  cqe_log [$];
  logic [39:0]           head_log [$];
  integer                seed      = 32'hdebe;
  int unsigned           cycle_cnt = 0;
  int unsigned           ack_wait  = 0;

  wq_mgr_top i_wq_mgr_top (.*);

  always #50 axis_aclk_i = ~axis_aclk_i;

  always @(posedge axis_aclk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic abort_run(input string msg);
    $display("error: %s", msg);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_req(input sq_req_t got, input sq_req_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_cqe(input cqe_t got, input cqe_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_head(input logic [39:0] got, input logic [39:0] exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_addr(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic expect_count(input int got, input int exp, input string what);
    if (got != exp) abort_run($sformatf("saw %0d %s where %0d were expected", got, what, exp));
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////
  function automatic logic [AXI_DATA_W-1:0] make_wqe(input logic [15:0] wr_id,
      input logic [7:0] op, input logic [31:0] len, input logic [63:0] laddr,
      input logic [63:0] raddr);
    logic [AXI_DATA_W-1:0] line;
    line          = '0;
    line[15:0]    = wr_id;
    line[95:32]   = laddr;
    line[127:96]  = len;
    line[135:128] = op;
    line[223:160] = raddr;
    return line;
  endfunction

  function automatic sq_req_t exp_req(input rc_op_e op, input logic [7:0] qp, input logic last,
      input logic [63:0] raddr, input logic [63:0] laddr, input logic [31:0] len);
    sq_req_t r;
    r.opcode      = op;
    r.qpn         = {8'h00, qp};
    r.last        = last;
    r.remote_addr = raddr;
    r.local_addr  = laddr;
    r.length      = len;
    return r;
  endfunction

  function automatic cqe_t exp_cqe(input logic [15:0] wr_id, input logic [7:0] op,
      input logic [7:0] status);
    cqe_t c;
    c.wr_id  = wr_id;
    c.opcode = op;
    c.status = status;
    return c;
  endfunction

  function automatic logic [63:0] wqe_addr(input int unsigned idx);
    return SQ_BASE + 64'(idx) * 64'd64;
  endfunction

  task automatic ring_doorbell(input logic [7:0] qp, input logic [31:0] head,
      input logic [31:0] prod);
    @(negedge axis_aclk_i);
    sq_updated_i  = 1'b1;
    qp_idx_i      = qp;
    sq_prod_idx_i = prod;
    cq_head_idx_i = head;
    sq_base_i     = SQ_BASE;
    cq_base_i     = CQ_BASE;
    @(negedge axis_aclk_i);
    sq_updated_i = 1'b0;
  endtask

  task automatic clear_logs();
    req_log.delete();
    ar_log.delete();
    aw_log.delete();
    cqe_log.delete();
    head_log.delete();
  endtask

  // the head report closes each element
  task automatic wait_heads(input int n);
    while (head_log.size() < n) @(negedge axis_aclk_i);
  endtask

  ////////////////////
  // bus responders
  ////////////////////
  always begin : read_slave
    logic [63:0] addr;
    @(negedge axis_aclk_i);
    if (arvalid_o) begin
      addr = araddr_o;
      ar_log.push_back(addr);
      arready_i = 1'b1;
      @(negedge axis_aclk_i);
      arready_i = 1'b0;
      rdata_i   = wqe_mem.exists(addr) ? wqe_mem[addr] : '0;
      rvalid_i  = 1'b1;
      rlast_i   = 1'b1;
      while (!rready_o) @(negedge axis_aclk_i);
      @(negedge axis_aclk_i);
      rvalid_i = 1'b0;
      rlast_i  = 1'b0;
    end
  end

  always begin : write_slave
    @(negedge axis_aclk_i);
    if (awvalid_o) begin
      aw_log.push_back(awaddr_o);
      awready_i = 1'b1;
      @(negedge axis_aclk_i);
      awready_i = 1'b0;
      while (!wvalid_o) @(negedge axis_aclk_i);
      if (!wlast_o) abort_run("the completion write beat came without wlast");
      cqe_log.push_back(wdata_o);
      wready_i = 1'b1;
      @(negedge axis_aclk_i);
      wready_i = 1'b0;
      if (!bready_o) abort_run("bready was low while a write response was due");
      bvalid_i = 1'b1;
      // head report follows bvalid in the same cycle
      #25;
      if (!cq_head_valid_o) abort_run("no completion-queue head report with the B response");
      head_log.push_back(cq_head_o);
      @(negedge axis_aclk_i);
      bvalid_i = 1'b0;
    end
  end

  always begin : req_slave
    int rnd;
    @(negedge axis_aclk_i);
    if (ack_valid_i) begin
      ack_valid_i = 1'b0;
    end else if (ack_wait != 0) begin
      ack_wait = ack_wait - 1;
      if (ack_wait == 0) ack_valid_i = 1'b1;
    end
    rnd            = $random(seed);
    sq_req_ready_i = rnd[0];
    if (sq_req_valid_o && sq_req_ready_i) begin
      req_log.push_back(sq_req_o);
      rnd = $random(seed);
      if (sq_req_o.last) ack_wait = 1 + rnd[1:0];
    end
  end

  // an offered ack is held one cycle and must be taken in it
  always begin : ack_monitor
    @(negedge axis_aclk_i);
    #25;
    if (ack_valid_i && !ack_ready_o) begin
      abort_run("ack_ready_o stayed low while an owed ack was offered");
    end
  end

  ////////////////////
  // directed cases
  ////////////////////
  task automatic single_write();
    wqe_mem[wqe_addr(7)] = make_wqe(16'h0101, 8'h00, 32'd1000, 64'hA000, 64'hB000);
    clear_logs();
    ring_doorbell(8'd3, 32'd7, 32'd8);
    wait_heads(1);
    expect_count(req_log.size(), 1, "requests for the write element");
    check_addr(ar_log[0], wqe_addr(7), "write element fetch address");
    check_req(req_log[0], exp_req(WRITE_ONLY, 8'd3, 1'b1, 64'hB000, 64'hA000, 32'd1000),
              "write only request");
    check_cqe(cqe_log[0], exp_cqe(16'h0101, 8'h00, 8'd0), "write completion");
    check_addr(aw_log[0], CQ_BASE + 64'd28, "write completion address");
    check_head(head_log[0], {8'd3, 32'd8}, "write head report");
  endtask

  task automatic split_send();
    wqe_mem[wqe_addr(10)] = make_wqe(16'h0202, 8'h02, 32'd10000, 64'h1_0000, 64'hDEAD_0000);
    clear_logs();
    ring_doorbell(8'd5, 32'd10, 32'd11);
    wait_heads(1);
    expect_count(req_log.size(), 3, "requests for the 10000-byte send");
    check_req(req_log[0], exp_req(SEND_FIRST, 8'd5, 1'b0, 64'd0, 64'h1_0000, 32'd4096),
              "send first");
    check_req(req_log[1], exp_req(SEND_MIDDLE, 8'd5, 1'b0, 64'd0, 64'h1_1000, 32'd4096),
              "send middle");
    check_req(req_log[2], exp_req(SEND_LAST, 8'd5, 1'b1, 64'd0, 64'h1_2000, 32'd1808),
              "send last");
    check_cqe(cqe_log[0], exp_cqe(16'h0202, 8'h02, 8'd0), "send completion");
  endtask

  task automatic long_read();
    wqe_mem[wqe_addr(20)] = make_wqe(16'h0303, 8'h04, 32'd9000, 64'h4000_0000, 64'h5000_0000);
    clear_logs();
    ring_doorbell(8'd9, 32'd20, 32'd21);
    wait_heads(1);
    expect_count(req_log.size(), 1, "requests for the read element");
    check_req(req_log[0],
              exp_req(READ_REQUEST, 8'd9, 1'b1, 64'h5000_0000, 64'h4000_0000, 32'd9000),
              "read request");
    check_head(head_log[0], {8'd9, 32'd21}, "read head report");
  endtask

  task automatic multi_element_job();
    logic [15:0] ids [3];
    logic [7:0]  ops [3];
    ids = '{16'h0410, 16'h0411, 16'h0412};
    ops = '{8'h00, 8'h02, 8'h04};
    wqe_mem[wqe_addr(2)] = make_wqe(ids[0], ops[0], 32'd100, 64'h2000, 64'h3000);
    wqe_mem[wqe_addr(3)] = make_wqe(ids[1], ops[1], 32'd5000, 64'h6000, 64'h7000);
    wqe_mem[wqe_addr(4)] = make_wqe(ids[2], ops[2], 32'd64, 64'h9000, 64'hA000);
    clear_logs();
    ring_doorbell(8'h21, 32'd2, 32'd5);
    wait_heads(3);
    expect_count(ar_log.size(), 3, "element fetches for head 2 to prod 5");
    expect_count(req_log.size(), 4, "requests for the three elements");
    check_req(req_log[0], exp_req(WRITE_ONLY, 8'h21, 1'b1, 64'h3000, 64'h2000, 32'd100),
              "first element request");
    check_req(req_log[1], exp_req(SEND_FIRST, 8'h21, 1'b0, 64'd0, 64'h6000, 32'd4096),
              "second element first request");
    check_req(req_log[2], exp_req(SEND_LAST, 8'h21, 1'b1, 64'd0, 64'h7000, 32'd904),
              "second element last request");
    check_req(req_log[3], exp_req(READ_REQUEST, 8'h21, 1'b1, 64'hA000, 64'h9000, 32'd64),
              "third element request");
    for (int i = 0; i < 3; i++) begin
      check_addr(ar_log[i], wqe_addr(2 + i), "element fetch order");
      check_addr(aw_log[i], CQ_BASE + 64'(2 + i) * 64'd4, "completion slot");
      check_cqe(cqe_log[i], exp_cqe(ids[i], ops[i], 8'd0), "element completion");
      check_head(head_log[i], {8'h21, 32'(3 + i)}, "head report order");
    end
  endtask

  task automatic empty_and_unknown();
    wqe_mem[wqe_addr(30)] = make_wqe(16'h0777, 8'h07, 32'd256, 64'hC000, 64'hD000);
    clear_logs();
    // prod equal to head must be dropped before the second doorbell
    ring_doorbell(8'h40, 32'd30, 32'd30);
    ring_doorbell(8'h40, 32'd30, 32'd31);
    wait_heads(1);
    expect_count(ar_log.size(), 1, "element fetches for the empty and unknown doorbells");
    expect_count(req_log.size(), 0, "requests for the unknown opcode");
    check_cqe(cqe_log[0], exp_cqe(16'h0777, 8'h07, 8'd1), "unknown opcode completion");
    check_addr(aw_log[0], CQ_BASE + 64'd120, "unknown opcode completion address");
    check_head(head_log[0], {8'h40, 32'd31}, "unknown opcode head report");
  endtask

  initial begin : main
    repeat (10) @(negedge axis_aclk_i);
    axis_rstn_i = 1'b1;
    single_write();
    split_send();
    long_read();
    multi_element_job();
    empty_and_unknown();
    @(negedge axis_aclk_i);
    if (i_wq_mgr_top.i_tb_wq_mgr_assert.fail_cnt != 0) begin
      $display("a bound handshake assertion failed during the run");
      $display(">>> FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- wq_mgr_top.f
hw/wq_mgr_pkg.sv
hw/wqe_fetch_if.sv
hw/cpl_write_if.sv
hw/sq_doorbell_queue.sv
hw/wqe_fetch.sv
hw/sq_segmenter.sv
hw/cq_writeback.sv
hw/wq_mgr_top.sv
verification/tb_wq_mgr_assert.sv
verification/tb_wq_mgr.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the wq_mgr testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_wq_mgr \
  -f wq_mgr_top.f -o tb_wq_mgr
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_wq_mgr > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
